/* design/rv32_defines.svh */
// global sizes and the reset vector of the RV32I core
// included by the package and by any module that needs raw widths
`ifndef RV32_DEFINES_SVH
`define RV32_DEFINES_SVH

// data path width, also address and instruction width
`define RV32_XLEN 32

// register index width, 32 architectural registers
`define RV32_REG_ADDR_W 5

// address of the first fetch after reset
`define RV32_RESET_PC 32'h0000_0000

// byte lanes on the data bus
// a word access sets all of them
`define RV32_SEL_W (`RV32_XLEN / 8)

`endif

/* design/rv32Pkg.sv */
// shared types of the RV32I core
// modules pull these in by a wildcard import in their header
`include "rv32_defines.svh"

package rv32Pkg;

    // data, address and instruction word
    typedef logic [`RV32_XLEN-1:0] wordT;

    // register index
    typedef logic [`RV32_REG_ADDR_W-1:0] regAddrT;

    // major opcodes that the core executes
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011
    } opcodeT;

    // ALU operations
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASSB
    } aluOpT;

    // load/store unit FSM
    typedef enum logic {
        LSU_IDLE,
        LSU_BUSY
    } lsuStateT;

endpackage

/* design/regFile.sv */
// 32 x 32 register file, two combinational read ports and one clocked write port
// x0 always reads as zero
`timescale 1ns/10ps

module regFile
    import rv32Pkg::*;
(
    input  logic    clk,
    // write port, takes effect at the rising edge
    input  logic    we,
    input  regAddrT waddr,
    input  wordT    wdata,
    // read ports, no clock needed
    input  regAddrT raddr1,
    input  regAddrT raddr2,
    output wordT    rdata1,
    output wordT    rdata2
);

    // architectural registers
    // entry 0 exists but is never seen on a read port
    wordT regs [32];

    // write port
    always_ff @(posedge clk)
    begin
        if (we)
        begin
            regs[waddr] <= wdata;
        end
    end

    // read ports
    // index 0 returns the hardwired zero even after a write to x0
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

/* design/instrDecoder.sv */
// combinational RV32I decoder for the ALU group, lui, lw and sw
// drives register indices, immediate, ALU op and the control flags
`timescale 1ns/10ps

module instrDecoder
    import rv32Pkg::*;
(
    input  wordT    instr,
    output regAddrT rs1,
    output regAddrT rs2,
    output regAddrT rd,
    output wordT    imm,
    output aluOpT   aluOp,
    output logic    useImm,
    output logic    regWrite,
    output logic    isLoad,
    output logic    isStore
);

    opcodeT     opcode;
    logic [2:0] funct3;
    wordT       immI;
    wordT       immS;
    wordT       immU;
    aluOpT      aluFunc;

    assign opcode = opcodeT'(instr[6:0]);
    assign funct3 = instr[14:12];

    // immediate formats
    // I and S are sign extended from bit 31
    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    // U puts imm[31:12] on top, zeros below
    assign immU = {instr[31:12], 12'b0};

    // funct3 map shared by OP and OP_IMM
    // bit 30 picks sub over add only for OP, sra over srl for both
    always_comb
    begin
        case (funct3)
            3'b000:  aluFunc = (opcode == OPC_OP && instr[30]) ? ALU_SUB : ALU_ADD;
            3'b001:  aluFunc = ALU_SLL;
            3'b010:  aluFunc = ALU_SLT;
            3'b011:  aluFunc = ALU_SLTU;
            3'b100:  aluFunc = ALU_XOR;
            3'b101:  aluFunc = instr[30] ? ALU_SRA : ALU_SRL;
            3'b110:  aluFunc = ALU_OR;
            default: aluFunc = ALU_AND;
        endcase
    end

    always_comb
    begin
        // defaults give a nop for unknown opcodes
        rs1      = instr[19:15];
        rs2      = instr[24:20];
        rd       = instr[11:7];
        imm      = '0;
        aluOp    = ALU_ADD;
        useImm   = 1'b0;
        regWrite = 1'b0;
        isLoad   = 1'b0;
        isStore  = 1'b0;

        case (opcode)
            OPC_OP:
            begin
                aluOp    = aluFunc;
                regWrite = 1'b1;
            end
            OPC_OP_IMM:
            begin
                // shift amount sits in imm[4:0]
                imm      = immI;
                aluOp    = aluFunc;
                useImm   = 1'b1;
                regWrite = 1'b1;
            end
            OPC_LUI:
            begin
                // immediate straight through, rs1 unused
                rs1      = '0;
                imm      = immU;
                aluOp    = ALU_PASSB;
                useImm   = 1'b1;
                regWrite = 1'b1;
            end
            OPC_LOAD:
            begin
                // address is rs1 + I immediate, write happens on ack
                imm      = immI;
                useImm   = 1'b1;
                regWrite = 1'b1;
                isLoad   = 1'b1;
            end
            OPC_STORE:
            begin
                // address is rs1 + S immediate, data from rs2
                imm      = immS;
                useImm   = 1'b1;
                isStore  = 1'b1;
            end
            default:
            begin
                regWrite = 1'b0;
            end
        endcase
    end

endmodule

/* design/alu.sv */
// combinational integer ALU for the RV32I register and immediate groups
// also forms load/store addresses and passes the lui immediate
`timescale 1ns/10ps

module alu
    import rv32Pkg::*;
(
    input  wordT  opA,
    input  wordT  opB,
    input  aluOpT aluOp,
    output wordT  result
);

    // shifts only look at the low five bits
    logic [4:0] shamt;
    logic       ltSigned;
    logic       ltUnsigned;

    assign shamt      = opB[4:0];
    assign ltSigned   = $signed(opA) < $signed(opB);
    assign ltUnsigned = opA < opB;

    always_comb
    begin
        case (aluOp)
            ALU_ADD:   result = opA + opB;
            ALU_SUB:   result = opA - opB;
            ALU_AND:   result = opA & opB;
            ALU_OR:    result = opA | opB;
            ALU_XOR:   result = opA ^ opB;
            ALU_SLL:   result = opA << shamt;
            ALU_SRL:   result = opA >> shamt;
            // sign bit fills from the left
            ALU_SRA:   result = wordT'($signed(opA) >>> shamt);
            // compares return 0 or 1
            ALU_SLT:   result = wordT'(ltSigned);
            ALU_SLTU:  result = wordT'(ltUnsigned);
            ALU_PASSB: result = opB;
            default:   result = '0;
        endcase
    end

endmodule

/* design/loadStoreUnit.sv */
// Wishbone classic master for one word load or store per memory instruction
// stalls the core from the decode cycle until the slave acks
`timescale 1ns/10ps
`include "rv32_defines.svh"

module loadStoreUnit
    import rv32Pkg::*;
(
    input  logic                  clk,
    input  logic                  rstN,
    // request from the core
    input  logic                  memStart,
    input  logic                  memWrite,
    input  wordT                  addr,
    input  wordT                  storeData,
    output logic                  stall,
    output wordT                  loadData,
    // Wishbone master side
    output logic                  wbCyc,
    output logic                  wbStb,
    output logic                  wbWe,
    output wordT                  wbAdr,
    output wordT                  wbDatOut,
    output logic [`RV32_SEL_W-1:0] wbSel,
    input  logic                  wbAck,
    input  wordT                  wbDatIn
);

    lsuStateT state;
    wordT     adrQ;
    wordT     datQ;
    logic     weQ;
    logic     busy;

    assign busy = (state == LSU_BUSY);

    // FSM
    // ack is only looked at while busy
    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            state <= LSU_IDLE;
        end
        else if (!busy && memStart)
        begin
            state <= LSU_BUSY;
        end
        else if (busy && wbAck)
        begin
            state <= LSU_IDLE;
        end
    end

    // request is captured in the decode cycle
    // held steady for the whole bus cycle
    always_ff @(posedge clk)
    begin
        if (!busy && memStart)
        begin
            adrQ <= addr;
            datQ <= storeData;
            weQ  <= memWrite;
        end
    end

    // stall covers the decode cycle and every wait state
    // drops in the ack cycle so the PC moves at that edge
    assign stall = (!busy && memStart) || (busy && !wbAck);

    // bus drive
    // cyc and stb fall the cycle after ack
    assign wbCyc    = busy;
    assign wbStb    = busy;
    assign wbWe     = busy && weQ;
    assign wbAdr    = adrQ;
    assign wbDatOut = datQ;
    // word access only
    assign wbSel    = '1;

    // read data goes straight to writeback in the ack cycle
    assign loadData = wbDatIn;

endmodule

/* design/rv32Core.sv */
// single-cycle RV32I core top for the ALU group, lui, lw and sw
// combinational instruction port and a Wishbone classic data port
`timescale 1ns/10ps
`include "rv32_defines.svh"

module rv32Core
    import rv32Pkg::*;
(
    input  logic                  clk,
    input  logic                  rstN,
    // instruction port returns data in the same cycle
    output wordT                  imemAddr,
    input  wordT                  imemData,
    // Wishbone data port
    output logic                  wbCyc,
    output logic                  wbStb,
    output logic                  wbWe,
    output wordT                  wbAdr,
    output wordT                  wbDatOut,
    output logic [`RV32_SEL_W-1:0] wbSel,
    input  logic                  wbAck,
    input  wordT                  wbDatIn
);

    wordT    pc;
    regAddrT rs1;
    regAddrT rs2;
    regAddrT rd;
    wordT    imm;
    aluOpT   aluOp;
    logic    useImm;
    logic    regWrite;
    logic    isLoad;
    logic    isStore;
    wordT    rdata1;
    wordT    rdata2;
    wordT    opB;
    wordT    aluResult;
    wordT    loadData;
    wordT    wbData;
    logic    stall;
    logic    rfWe;

    // program counter
    // sequential only and held while a memory access is pending
    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            pc <= `RV32_RESET_PC;
        end
        else if (!stall)
        begin
            pc <= pc + wordT'(4);
        end
    end

    assign imemAddr = pc;

    instrDecoder u_instrDecoder (
        .instr    (imemData),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .imm      (imm),
        .aluOp    (aluOp),
        .useImm   (useImm),
        .regWrite (regWrite),
        .isLoad   (isLoad),
        .isStore  (isStore)
    );

    // operand B from register or immediate
    assign opB = useImm ? imm : rdata2;

    alu u_alu (
        .opA    (rdata1),
        .opB    (opB),
        .aluOp  (aluOp),
        .result (aluResult)
    );

    // writeback source
    assign wbData = isLoad ? loadData : aluResult;

    // one write per instruction
    // a load is held off by stall until its ack cycle
    // no writes while in reset
    assign rfWe = regWrite && !stall && rstN;

    regFile u_regFile (
        .clk    (clk),
        .we     (rfWe),
        .waddr  (rd),
        .wdata  (wbData),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    // address from the ALU and store data from rs2
    loadStoreUnit u_loadStoreUnit (
        .clk       (clk),
        .rstN      (rstN),
        .memStart  (isLoad || isStore),
        .memWrite  (isStore),
        .addr      (aluResult),
        .storeData (rdata2),
        .stall     (stall),
        .loadData  (loadData),
        .wbCyc     (wbCyc),
        .wbStb     (wbStb),
        .wbWe      (wbWe),
        .wbAdr     (wbAdr),
        .wbDatOut  (wbDatOut),
        .wbSel     (wbSel),
        .wbAck     (wbAck),
        .wbDatIn   (wbDatIn)
    );

endmodule

/* tb/coreChecker.sv */
// ISA reference model that watches the DUT ports and checks every Wishbone
// transfer at its ack edge against the expected ordered transaction list
`timescale 1ns/10ps
`include "rv32_defines.svh"

module coreChecker
    import rv32Pkg::*;
(
    input  logic                   clk,
    input  logic                   rstN,
    input  wordT                   imemAddr,
    input  logic                   wbCyc,
    input  logic                   wbStb,
    input  logic                   wbWe,
    input  wordT                   wbAdr,
    input  wordT                   wbDatOut,
    input  logic [`RV32_SEL_W-1:0] wbSel,
    input  logic                   wbAck,
    input  wordT                   wbDatIn,
    output int                     errorCount,
    output int                     seenCount,
    output int                     expectedCount
);

    localparam int memWords = 512;

    wordT progQ [$];
    wordT memImage [memWords];
    wordT regs [32];
    // expected transfers in program order
    bit   expWe [$];
    wordT expAdr [$];
    wordT expDat [$];

    // request seen at the previous edge without ack
    logic pendQ;
    logic weHeld;
    wordT adrHeld;
    wordT datHeld;
    bit   fetchChecked;
    int   resetEdges;

    // expectedCount is only written by buildExpected
    initial
    begin
        errorCount    = 0;
        seenCount     = 0;
        pendQ         = 1'b0;
        fetchChecked  = 1'b0;
        resetEdges    = 0;
    end

    task automatic addInstr(wordT instr);
        progQ.push_back(instr);
    endtask

    task automatic setMemWord(int idx, wordT value);
        memImage[idx] = value;
    endtask

    task automatic reportMismatch(string name, wordT expected, wordT actual);
        $display("FAIL t=%0t %s expected %h actual %h", $time, name, expected, actual);
        errorCount++;
    endtask

    task automatic reportProblem(string what);
        $display("ERROR: t=%0t %s", $time, what);
        errorCount++;
    endtask

    // funct3 semantics shared by OP and OP-IMM
    function automatic wordT aluRef(logic [2:0] f3, logic alt, wordT a, wordT b);
        wordT r;
        case (f3)
            3'b000:  r = alt ? a - b : a + b;
            3'b001:  r = a << b[4:0];
            3'b010:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  r = (a < b) ? 32'd1 : 32'd0;
            3'b100:  r = a ^ b;
            3'b101:
            begin
                if (alt)
                    r = $signed(a) >>> b[4:0];
                else
                    r = a >> b[4:0];
            end
            3'b110:  r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    // runs the whole program once and records each lw/sw
    task automatic buildExpected();
        wordT       instr;
        wordT       a;
        wordT       b;
        wordT       immI;
        wordT       immS;
        wordT       addr;
        wordT       result;
        logic [2:0] f3;
        bit         writeRd;
        int         n;
        for (n = 0; n < 32; n++)
            regs[n] = '0;
        for (n = 0; n < progQ.size(); n++)
        begin
            instr   = progQ[n];
            f3      = instr[14:12];
            a       = regs[instr[19:15]];
            b       = regs[instr[24:20]];
            immI    = {{20{instr[31]}}, instr[31:20]};
            immS    = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            writeRd = 1'b0;
            result  = '0;
            case (instr[6:0])
                7'b0110011:
                begin
                    result  = aluRef(f3, instr[30], a, b);
                    writeRd = 1'b1;
                end
                7'b0010011:
                begin
                    // bit 30 selects srai only
                    result  = aluRef(f3, (f3 == 3'b101) && instr[30], a, immI);
                    writeRd = 1'b1;
                end
                7'b0110111:
                begin
                    result  = {instr[31:12], 12'b0};
                    writeRd = 1'b1;
                end
                7'b0000011:
                begin
                    addr    = a + immI;
                    result  = memImage[addr[10:2]];
                    writeRd = 1'b1;
                    expWe.push_back(1'b0);
                    expAdr.push_back(addr);
                    expDat.push_back(result);
                end
                7'b0100011:
                begin
                    addr = a + immS;
                    memImage[addr[10:2]] = b;
                    expWe.push_back(1'b1);
                    expAdr.push_back(addr);
                    expDat.push_back(b);
                end
                default:
                begin
                    writeRd = 1'b0;
                end
            endcase
            // x0 never changes
            if (writeRd && instr[11:7] != 5'd0)
                regs[instr[11:7]] = result;
        end
        expectedCount = expAdr.size();
    endtask

    // one transfer at its ack edge
    task automatic compareTransfer();
        if (seenCount >= expectedCount)
            reportProblem("extra bus transaction beyond the model's list");
        else
        begin
            if (wbWe !== expWe[seenCount])
                reportMismatch("wbWe", wordT'(expWe[seenCount]), wordT'(wbWe));
            if (wbAdr !== expAdr[seenCount])
                reportMismatch("wbAdr", expAdr[seenCount], wbAdr);
            if (wbSel !== 4'b1111)
                reportMismatch("wbSel", 32'hf, wordT'(wbSel));
            if (expWe[seenCount] && wbDatOut !== expDat[seenCount])
                reportMismatch("wbDatOut", expDat[seenCount], wbDatOut);
            if (!expWe[seenCount] && wbDatIn !== expDat[seenCount])
                reportMismatch("wbDatIn", expDat[seenCount], wbDatIn);
        end
        seenCount++;
    endtask

    task automatic checkCount();
        if (seenCount < expectedCount)
            reportProblem($sformatf("%0d bus transactions missing",
                expectedCount - seenCount));
    endtask

    always @(posedge clk)
    begin
        if (!rstN)
        begin
            // first edge only clears the FSM
            if (resetEdges > 0)
            begin
                if (wbCyc !== 1'b0)
                    reportMismatch("wbCyc", 32'd0, wordT'(wbCyc));
                if (wbStb !== 1'b0)
                    reportMismatch("wbStb", 32'd0, wordT'(wbStb));
            end
            resetEdges++;
            fetchChecked = 1'b0;
            pendQ        = 1'b0;
        end
        else
        begin
            if (!fetchChecked)
            begin
                if (imemAddr !== `RV32_RESET_PC)
                    reportMismatch("imemAddr", `RV32_RESET_PC, imemAddr);
                fetchChecked = 1'b1;
            end
            if (wbCyc !== wbStb)
                reportMismatch("wbStb", wordT'(wbCyc), wordT'(wbStb));
            // request held steady until ack
            if (pendQ)
            begin
                if (wbCyc !== 1'b1)
                    reportProblem("bus request dropped before ack");
                else
                begin
                    if (wbAdr !== adrHeld)
                        reportMismatch("wbAdr", adrHeld, wbAdr);
                    if (wbWe !== weHeld)
                        reportMismatch("wbWe", wordT'(weHeld), wordT'(wbWe));
                    if (weHeld && wbDatOut !== datHeld)
                        reportMismatch("wbDatOut", datHeld, wbDatOut);
                end
            end
            if (wbCyc === 1'b1 && wbStb === 1'b1 && wbAck === 1'b1)
                compareTransfer();
            pendQ   = (wbCyc === 1'b1) && (wbStb === 1'b1) && (wbAck !== 1'b1);
            weHeld  = wbWe;
            adrHeld = wbAdr;
            datHeld = wbDatOut;
        end
    end

endmodule

/* tb/tbRv32Core.sv */
// testbench top with clock, reset, random program and instruction ROM
// the Wishbone slave memory adds random waits and coreChecker compares
`timescale 1ns/10ps
`include "rv32_defines.svh"

module tbRv32Core
    import rv32Pkg::*;
();

    localparam int         romDepth    = 512;
    localparam int         memWords    = 512;
    localparam int         randomCount = 200;
    // dump area for the final register stores in the top 32 words
    localparam int         dumpBase    = 1920;
    localparam wordT       nopInstr    = 32'h0000_0013;
    localparam logic [6:0] opImm       = 7'b0010011;
    localparam logic [6:0] opLoad      = 7'b0000011;

    logic                   clk;
    logic                   rstN;
    wordT                   imemAddr;
    wordT                   imemData;
    logic                   wbCyc;
    logic                   wbStb;
    logic                   wbWe;
    wordT                   wbAdr;
    wordT                   wbDatOut;
    logic [`RV32_SEL_W-1:0] wbSel;
    logic                   wbAck;
    wordT                   wbDatIn;

    wordT   rom [romDepth];
    wordT   mem [memWords];
    int     progLen;
    int     cycleCount = 0;
    int     cycleLimit;
    int     errorCount;
    int     seenCount;
    int     expectedCount;
    int     i;
    integer seed;
    bit     timedOut;

    // slave copy of the bus sampled at the edge
    logic   reqQ;
    logic   ackQ;
    logic   weQ;
    wordT   adrQ;
    wordT   datQ;
    int     waitLeft;

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 1;
    end

    rv32Core u_rv32Core (
        .clk      (clk),
        .rstN     (rstN),
        .imemAddr (imemAddr),
        .imemData (imemData),
        .wbCyc    (wbCyc),
        .wbStb    (wbStb),
        .wbWe     (wbWe),
        .wbAdr    (wbAdr),
        .wbDatOut (wbDatOut),
        .wbSel    (wbSel),
        .wbAck    (wbAck),
        .wbDatIn  (wbDatIn)
    );

    coreChecker u_coreChecker (
        .clk           (clk),
        .rstN          (rstN),
        .imemAddr      (imemAddr),
        .wbCyc         (wbCyc),
        .wbStb         (wbStb),
        .wbWe          (wbWe),
        .wbAdr         (wbAdr),
        .wbDatOut      (wbDatOut),
        .wbSel         (wbSel),
        .wbAck         (wbAck),
        .wbDatIn       (wbDatIn),
        .errorCount    (errorCount),
        .seenCount     (seenCount),
        .expectedCount (expectedCount)
    );

    // instruction ROM returns a nop past the program
    assign imemData = (imemAddr < romDepth * 4) ? rom[imemAddr[10:2]] : nopInstr;

    function automatic int unsigned pick(int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // RV32I encodings
    function automatic wordT encodeR(logic [6:0] f7, regAddrT rs2, regAddrT rs1,
                                     logic [2:0] f3, regAddrT rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic wordT encodeI(logic [11:0] imm, regAddrT rs1, logic [2:0] f3,
                                     regAddrT rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic wordT encodeS(logic [11:0] imm, regAddrT rs2, regAddrT rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic wordT encodeU(logic [19:0] imm, regAddrT rd);
        return {imm, rd, 7'b0110111};
    endfunction

    // ROM and checker get the same instruction stream
    task automatic appendInstr(wordT instr);
        rom[progLen] = instr;
        u_coreChecker.addInstr(instr);
        progLen++;
    endtask

    task automatic buildProgram();
        wordT        value;
        wordT        upper;
        regAddrT     rd;
        regAddrT     rs1;
        regAddrT     rs2;
        logic [2:0]  f3;
        logic [4:0]  shamt;
        logic [11:0] imm;
        logic        alt;
        int          kind;
        int          n;
        // x1..x31 from lui/addi pairs
        // the +0x800 undoes the addi sign extension
        for (n = 1; n < 32; n++)
        begin
            value = $random(seed);
            upper = value + 32'h800;
            appendInstr(encodeU(upper[31:12], regAddrT'(n)));
            appendInstr(encodeI(value[11:0], regAddrT'(n), 3'b000, regAddrT'(n), opImm));
        end
        // random body where rd may be x0
        for (n = 0; n < randomCount; n++)
        begin
            kind  = pick(10);
            rd    = regAddrT'(pick(32));
            rs1   = regAddrT'(pick(32));
            rs2   = regAddrT'(pick(32));
            f3    = 3'(pick(8));
            shamt = 5'(pick(32));
            alt   = 1'(pick(2));
            if (kind < 3)
            begin
                // funct7 bit 30 only for sub and sra
                appendInstr(encodeR(((f3 == 3'b000 || f3 == 3'b101) && alt) ?
                    7'b0100000 : 7'b0000000, rs2, rs1, f3, rd));
            end
            else if (kind < 6)
            begin
                if (f3 == 3'b001)
                    imm = {7'b0000000, shamt};
                else if (f3 == 3'b101)
                    imm = {1'b0, alt, 5'b00000, shamt};
                else
                    imm = 12'(pick(4096));
                appendInstr(encodeI(imm, rs1, f3, rd, opImm));
            end
            else if (kind == 6)
                appendInstr(encodeU(20'(pick(1 << 20)), rd));
            else if (kind < 9)
                appendInstr(encodeI(12'(pick(memWords) * 4), 5'd0, 3'b010, rd, opLoad));
            else
                appendInstr(encodeS(12'(pick(memWords) * 4), rs2, 5'd0));
        end
        // final register dump
        for (n = 0; n < 32; n++)
            appendInstr(encodeS(12'(dumpBase + 4 * n), regAddrT'(n), 5'd0));
    endtask

    // Wishbone slave with 0 to 3 wait cycles driving 1 ns after the edge
    always @(posedge clk)
    begin
        reqQ = wbCyc && wbStb;
        ackQ = wbAck;
        weQ  = wbWe;
        adrQ = wbAdr;
        datQ = wbDatOut;
        #1;
        if (!rstN)
        begin
            wbAck    = 1'b0;
            waitLeft = -1;
        end
        else if (ackQ)
        begin
            // transfer ends at this edge
            if (weQ)
                mem[adrQ[10:2]] = datQ;
            wbAck    = 1'b0;
            wbDatIn  = $random(seed);
            waitLeft = -1;
        end
        else if (reqQ)
        begin
            if (waitLeft < 0)
                waitLeft = pick(4);
            if (waitLeft == 0)
            begin
                wbAck   = 1'b1;
                wbDatIn = mem[adrQ[10:2]];
            end
            else
                waitLeft--;
        end
    end

    initial
    begin
        seed     = 32'hba44_f728;
        rstN     = 1'b0;
        wbAck    = 1'b0;
        wbDatIn  = '0;
        progLen  = 0;
        timedOut = 1'b0;
        for (i = 0; i < romDepth; i++)
            rom[i] = nopInstr;
        // random memory image with a copy in the checker
        for (i = 0; i < memWords; i++)
        begin
            mem[i] = $random(seed);
            u_coreChecker.setMemWord(i, mem[i]);
        end
        buildProgram();
        u_coreChecker.buildExpected();
        cycleLimit = progLen * 6 + 100;

        repeat (4) @(posedge clk);
        #1 rstN = 1'b1;

        while (seenCount < expectedCount && cycleCount < cycleLimit)
            @(posedge clk);
        if (seenCount < expectedCount)
        begin
            timedOut = 1'b1;
            $display("ERROR: timeout after %0d cycles, only %0d of %0d bus transactions seen",
                cycleCount, seenCount, expectedCount);
        end
        else
        begin
            // a few more cycles so extra transactions show up
            repeat (20) @(posedge clk);
        end
        u_coreChecker.checkCount();

        $display("errors %0d, bus transactions %0d of %0d, cycles %0d",
            errorCount, seenCount, expectedCount, cycleCount);
        if (errorCount == 0 && !timedOut)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

/* project.f */
+incdir+design
design/rv32Pkg.sv
design/regFile.sv
design/instrDecoder.sv
design/alu.sv
design/loadStoreUnit.sv
design/rv32Core.sv
tb/coreChecker.sv
tb/tbRv32Core.sv

/* Bender.yml */
package:
  name: rv32_core

export_include_dirs:
  - design

sources:
  # core RTL, package first
  - include_dirs:
      - design
    files:
      - design/rv32Pkg.sv
      - design/regFile.sv
      - design/instrDecoder.sv
      - design/alu.sv
      - design/loadStoreUnit.sv
      - design/rv32Core.sv

  # testbench, top is tbRv32Core
  - target: test
    include_dirs:
      - design
    files:
      - tb/coreChecker.sv
      - tb/tbRv32Core.sv
